// ==== common/mipsPkg.sv ====
package mipsPkg;

    // word sized data, address and instruction
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // instruction fields
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // alu operation and execute forward select
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  fwdSel_t;

    // primary opcodes, funct decides for SPECIAL
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_ORI     = 6'h0D;
    localparam opcode_t OP_LUI     = 6'h0F;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2B;

    // funct codes of the supported R-type ops
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2A;

    // alu operations
    localparam aluOp_t ALU_ADD = 4'd0;
    localparam aluOp_t ALU_SUB = 4'd1;
    localparam aluOp_t ALU_AND = 4'd2;
    localparam aluOp_t ALU_OR  = 4'd3;
    localparam aluOp_t ALU_SLT = 4'd4;
    localparam aluOp_t ALU_SLL = 4'd5;
    localparam aluOp_t ALU_LUI = 4'd6;

    // execute operand sources
    localparam fwdSel_t FWD_RF  = 2'b00;
    localparam fwdSel_t FWD_WB  = 2'b01;
    localparam fwdSel_t FWD_MEM = 2'b10;

endpackage

// ==== common/hazardIf.sv ====
`timescale 1ns/10ps

interface hazardIf;

    // source and destination registers per stage
    mipsPkg::regAddr_t rsD;
    mipsPkg::regAddr_t rtD;
    mipsPkg::regAddr_t rsE;
    mipsPkg::regAddr_t rtE;
    mipsPkg::regAddr_t writeRegE;
    mipsPkg::regAddr_t writeRegM;
    mipsPkg::regAddr_t writeRegW;

    // control flags from the decoder pipeline
    logic branchD;
    logic regWriteE;
    logic regWriteM;
    logic regWriteW;
    logic memToRegE;
    logic memToRegM;

    // stall, flush and forward controls
    logic stallF;
    logic stallD;
    logic flushE;
    logic forwardAD;
    logic forwardBD;
    mipsPkg::fwdSel_t forwardAE;
    mipsPkg::fwdSel_t forwardBE;

    modport hazard (
        input  rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
        input  branchD, regWriteE, regWriteM, regWriteW, memToRegE, memToRegM,
        output stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
    );

    modport pipe (
        output rsD, rtD, rsE, rtE, writeRegE, writeRegM, writeRegW,
        input  stallF, stallD, flushE, forwardAD, forwardBD, forwardAE, forwardBE
    );

    modport ctrl (
        output branchD, regWriteE, regWriteM, regWriteW, memToRegE, memToRegM
    );

endinterface

// ==== datapath/regFile.sv ====
`timescale 1ns/10ps

module regFile (
    input  logic              clk,
    input  logic              reset_i,
    input  mipsPkg::regAddr_t raddr1_i,
    input  mipsPkg::regAddr_t raddr2_i,
    input  mipsPkg::regAddr_t waddr_i,
    input  logic              we_i,
    input  mipsPkg::word_t    wdata_i,
    output mipsPkg::word_t    rdata1_o,
    output mipsPkg::word_t    rdata2_o
);

    mipsPkg::word_t regs [32];

    // register 0 is never written
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // a write in flight wins over the stored value
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && raddr1_i == waddr_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && raddr2_i == waddr_i) ? wdata_i : regs[raddr2_i];

endmodule

// ==== datapath/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  mipsPkg::word_t    a_i,
    input  mipsPkg::word_t    b_i,
    input  mipsPkg::regAddr_t shamt_i,
    input  mipsPkg::aluOp_t   op_i,
    output mipsPkg::word_t    result_o
);

    always_comb begin
        case (op_i)
            // addu, addiu and load/store address, no overflow trap
            mipsPkg::ALU_ADD: result_o = a_i + b_i;
            mipsPkg::ALU_SUB: result_o = a_i - b_i;
            mipsPkg::ALU_AND: result_o = a_i & b_i;
            mipsPkg::ALU_OR:  result_o = a_i | b_i;
            // signed compare
            mipsPkg::ALU_SLT: result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            // sll shifts rt, rs field is ignored
            mipsPkg::ALU_SLL: result_o = b_i << shamt_i;
            // immediate into upper half
            mipsPkg::ALU_LUI: result_o = {b_i[15:0], 16'h0000};
            default:          result_o = a_i + b_i;
        endcase
    end

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
    hazardIf.hazard hzd
);

    logic lwStall;
    logic branchStall;

    // a writing stage targets this source, register 0 never matches
    function automatic logic hit(
        input mipsPkg::regAddr_t src,
        input mipsPkg::regAddr_t dst,
        input logic              we
    );
        return we && src != '0 && src == dst;
    endfunction

    // memory stage is younger, so it takes priority over writeback
    function automatic mipsPkg::fwdSel_t fwdSel(
        input mipsPkg::regAddr_t src,
        input mipsPkg::regAddr_t dstM,
        input logic              weM,
        input mipsPkg::regAddr_t dstW,
        input logic              weW
    );
        if (hit(src, dstM, weM)) begin
            return mipsPkg::FWD_MEM;
        end else if (hit(src, dstW, weW)) begin
            return mipsPkg::FWD_WB;
        end
        return mipsPkg::FWD_RF;
    endfunction

    // execute operands
    assign hzd.forwardAE = fwdSel(hzd.rsE, hzd.writeRegM, hzd.regWriteM,
                                  hzd.writeRegW, hzd.regWriteW);
    assign hzd.forwardBE = fwdSel(hzd.rtE, hzd.writeRegM, hzd.regWriteM,
                                  hzd.writeRegW, hzd.regWriteW);

    // branch compare, writeback goes through the regfile bypass
    assign hzd.forwardAD = hit(hzd.rsD, hzd.writeRegM, hzd.regWriteM);
    assign hzd.forwardBD = hit(hzd.rtD, hzd.writeRegM, hzd.regWriteM);

    // load in execute feeds the next instruction
    assign lwStall = hit(hzd.rsD, hzd.writeRegE, hzd.memToRegE) ||
                     hit(hzd.rtD, hzd.writeRegE, hzd.memToRegE);

    // branch waits for an alu result in E or load data in M
    assign branchStall = hzd.branchD &&
                         (hit(hzd.rsD, hzd.writeRegE, hzd.regWriteE) ||
                          hit(hzd.rtD, hzd.writeRegE, hzd.regWriteE) ||
                          hit(hzd.rsD, hzd.writeRegM, hzd.memToRegM) ||
                          hit(hzd.rtD, hzd.writeRegM, hzd.memToRegM));

    // hold F and D, bubble into E
    assign hzd.stallF = lwStall | branchStall;
    assign hzd.stallD = lwStall | branchStall;
    assign hzd.flushE = lwStall | branchStall;

endmodule

// ==== hdl/controlDecoder.sv ====
`timescale 1ns/10ps

module controlDecoder (
    input  logic            clk,
    input  logic            reset_i,
    input  mipsPkg::word_t  instrD_i,
    input  logic            stallD_i,
    input  logic            flushE_i,
    output logic            branchD_o,
    output logic            branchNeD_o,
    output logic            jumpD_o,
    output logic            regDstE_o,
    output logic            aluSrcE_o,
    output mipsPkg::aluOp_t aluOpE_o,
    output logic            memWriteM_o,
    output logic            memToRegW_o,
    output logic            regWriteW_o,
    hazardIf.ctrl           hzd
);

    mipsPkg::opcode_t opD;
    mipsPkg::funct_t  fnD;

    // decode stage
    logic            isBeqD;
    logic            isBneD;
    logic            isJumpD;
    logic            regWriteD;
    logic            memToRegD;
    logic            memWriteD;
    logic            regDstD;
    logic            aluSrcD;
    mipsPkg::aluOp_t aluOpD;

    // execute and memory stage
    logic regWriteE;
    logic memToRegE;
    logic memWriteE;
    logic regWriteM;
    logic memToRegM;

    assign opD = instrD_i[31:26];
    assign fnD = instrD_i[5:0];

    always_comb begin
        isBeqD    = 1'b0;
        isBneD    = 1'b0;
        isJumpD   = 1'b0;
        regWriteD = 1'b0;
        memToRegD = 1'b0;
        memWriteD = 1'b0;
        regDstD   = 1'b0;
        aluSrcD   = 1'b0;
        aluOpD    = mipsPkg::ALU_ADD;
        case (opD)
            // R-type writes rd
            mipsPkg::OP_SPECIAL: begin
                regWriteD = 1'b1;
                regDstD   = 1'b1;
                case (fnD)
                    mipsPkg::FN_ADDU: aluOpD = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUBU: aluOpD = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND:  aluOpD = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   aluOpD = mipsPkg::ALU_OR;
                    mipsPkg::FN_SLT:  aluOpD = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLL:  aluOpD = mipsPkg::ALU_SLL;
                    // unsupported funct acts as a nop
                    default:          regWriteD = 1'b0;
                endcase
            end
            // immediate ops write rt
            mipsPkg::OP_ADDIU: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            mipsPkg::OP_ORI: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluOpD    = mipsPkg::ALU_OR;
            end
            mipsPkg::OP_LUI: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluOpD    = mipsPkg::ALU_LUI;
            end
            // address is base plus offset
            mipsPkg::OP_LW: begin
                regWriteD = 1'b1;
                memToRegD = 1'b1;
                aluSrcD   = 1'b1;
            end
            mipsPkg::OP_SW: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            mipsPkg::OP_BEQ: isBeqD  = 1'b1;
            mipsPkg::OP_BNE: isBneD  = 1'b1;
            mipsPkg::OP_J:   isJumpD = 1'b1;
            default: ;
        endcase
    end

    // redirect only once operands are final
    assign branchD_o   = isBeqD & ~stallD_i;
    assign branchNeD_o = isBneD & ~stallD_i;
    assign jumpD_o     = isJumpD & ~stallD_i;

    // flush turns E into a bubble that writes nothing
    always_ff @(posedge clk) begin
        if (reset_i || flushE_i) begin
            regWriteE <= 1'b0;
            memToRegE <= 1'b0;
            memWriteE <= 1'b0;
            regDstE_o <= 1'b0;
            aluSrcE_o <= 1'b0;
            aluOpE_o  <= mipsPkg::ALU_ADD;
        end else begin
            regWriteE <= regWriteD;
            memToRegE <= memToRegD;
            memWriteE <= memWriteD;
            regDstE_o <= regDstD;
            aluSrcE_o <= aluSrcD;
            aluOpE_o  <= aluOpD;
        end
    end

    // E to M to W
    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteM   <= 1'b0;
            memToRegM   <= 1'b0;
            memWriteM_o <= 1'b0;
            regWriteW_o <= 1'b0;
            memToRegW_o <= 1'b0;
        end else begin
            regWriteM   <= regWriteE;
            memToRegM   <= memToRegE;
            memWriteM_o <= memWriteE;
            regWriteW_o <= regWriteM;
            memToRegW_o <= memToRegM;
        end
    end

    // hazard unit view, branch covers beq and bne
    assign hzd.branchD   = isBeqD | isBneD;
    assign hzd.regWriteE = regWriteE;
    assign hzd.regWriteM = regWriteM;
    assign hzd.regWriteW = regWriteW_o;
    assign hzd.memToRegE = memToRegE;
    assign hzd.memToRegM = memToRegM;

endmodule

// ==== datapath/datapath.sv ====
`timescale 1ns/10ps

module datapath #(
    parameter mipsPkg::word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic           clk,
    input  logic           reset_i,
    input  mipsPkg::word_t instrF_i,
    input  mipsPkg::word_t dataRdataM_i,
    output mipsPkg::word_t pcF_o,
    output mipsPkg::word_t dataAddrM_o,
    output logic [3:0]     dataWenM_o,
    output mipsPkg::word_t dataWdataM_o
);

    hazardIf hzd ();

    // controls from the decoder pipeline
    logic            branchD;
    logic            branchNeD;
    logic            jumpD;
    logic            regDstE;
    logic            aluSrcE;
    logic            memWriteM;
    logic            memToRegW;
    logic            regWriteW;
    mipsPkg::aluOp_t aluOpE;

    // fetch
    mipsPkg::word_t pcF;
    mipsPkg::word_t pcPlus4F;
    mipsPkg::word_t pcNextF;

    // decode
    mipsPkg::word_t instrD;
    mipsPkg::word_t pcPlus4D;
    mipsPkg::word_t rdata1D;
    mipsPkg::word_t rdata2D;
    mipsPkg::word_t cmpAD;
    mipsPkg::word_t cmpBD;
    mipsPkg::word_t immD;
    mipsPkg::word_t branchTargetD;
    mipsPkg::word_t jumpTargetD;
    logic           takenD;

    // execute
    mipsPkg::word_t    regAE;
    mipsPkg::word_t    regBE;
    mipsPkg::word_t    immE;
    mipsPkg::word_t    srcAE;
    mipsPkg::word_t    srcBE;
    mipsPkg::word_t    writeDataE;
    mipsPkg::word_t    aluOutE;
    mipsPkg::regAddr_t rsE;
    mipsPkg::regAddr_t rtE;
    mipsPkg::regAddr_t rdE;
    mipsPkg::regAddr_t shamtE;
    mipsPkg::regAddr_t writeRegE;

    // memory and writeback
    mipsPkg::word_t    aluOutM;
    mipsPkg::word_t    writeDataM;
    mipsPkg::regAddr_t writeRegM;
    mipsPkg::word_t    aluOutW;
    mipsPkg::word_t    readDataW;
    mipsPkg::word_t    resultW;
    mipsPkg::regAddr_t writeRegW;

    // execute operand mux, same for A and B
    function automatic mipsPkg::word_t fwdMux(
        input mipsPkg::fwdSel_t sel,
        input mipsPkg::word_t   rf,
        input mipsPkg::word_t   wb,
        input mipsPkg::word_t   mem
    );
        case (sel)
            mipsPkg::FWD_MEM: return mem;
            mipsPkg::FWD_WB:  return wb;
            default:          return rf;
        endcase
    endfunction

    // fetch: jump beats branch, delay slot is already in F
    assign pcPlus4F = pcF + 32'd4;
    assign pcNextF  = jumpD  ? jumpTargetD :
                      takenD ? branchTargetD : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcF <= RESET_PC;
        end else if (!hzd.stallF) begin
            pcF <= pcNextF;
        end
    end

    assign pcF_o = pcF;

    // F/D register, held on stall
    always_ff @(posedge clk) begin
        if (reset_i) begin
            instrD   <= '0;
            pcPlus4D <= '0;
        end else if (!hzd.stallD) begin
            instrD   <= instrF_i;
            pcPlus4D <= pcPlus4F;
        end
    end

    // decode
    assign hzd.rsD = instrD[25:21];
    assign hzd.rtD = instrD[20:16];

    controlDecoder uCtrl (
        .clk         (clk),
        .reset_i     (reset_i),
        .instrD_i    (instrD),
        .stallD_i    (hzd.stallD),
        .flushE_i    (hzd.flushE),
        .branchD_o   (branchD),
        .branchNeD_o (branchNeD),
        .jumpD_o     (jumpD),
        .regDstE_o   (regDstE),
        .aluSrcE_o   (aluSrcE),
        .aluOpE_o    (aluOpE),
        .memWriteM_o (memWriteM),
        .memToRegW_o (memToRegW),
        .regWriteW_o (regWriteW),
        .hzd         (hzd)
    );

    regFile uRegFile (
        .clk      (clk),
        .reset_i  (reset_i),
        .raddr1_i (hzd.rsD),
        .raddr2_i (hzd.rtD),
        .waddr_i  (writeRegW),
        .we_i     (regWriteW),
        .wdata_i  (resultW),
        .rdata1_o (rdata1D),
        .rdata2_o (rdata2D)
    );

    // ori zero-extends, everything else sign-extends
    assign immD = (instrD[31:26] == mipsPkg::OP_ORI) ? {16'h0000, instrD[15:0]} :
                                                       {{16{instrD[15]}}, instrD[15:0]};
    assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
    assign jumpTargetD   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

    // compare sees the memory stage result early
    assign cmpAD  = hzd.forwardAD ? aluOutM : rdata1D;
    assign cmpBD  = hzd.forwardBD ? aluOutM : rdata2D;
    assign takenD = (branchD && cmpAD == cmpBD) || (branchNeD && cmpAD != cmpBD);

    // D/E register, flush inserts a bubble
    always_ff @(posedge clk) begin
        if (reset_i || hzd.flushE) begin
            regAE  <= '0;
            regBE  <= '0;
            immE   <= '0;
            rsE    <= '0;
            rtE    <= '0;
            rdE    <= '0;
            shamtE <= '0;
        end else begin
            regAE  <= rdata1D;
            regBE  <= rdata2D;
            immE   <= immD;
            rsE    <= instrD[25:21];
            rtE    <= instrD[20:16];
            rdE    <= instrD[15:11];
            shamtE <= instrD[10:6];
        end
    end

    // execute
    assign srcAE      = fwdMux(hzd.forwardAE, regAE, resultW, aluOutM);
    assign writeDataE = fwdMux(hzd.forwardBE, regBE, resultW, aluOutM);
    assign srcBE      = aluSrcE ? immE : writeDataE;
    assign writeRegE  = regDstE ? rdE : rtE;

    alu uAlu (
        .a_i      (srcAE),
        .b_i      (srcBE),
        .shamt_i  (shamtE),
        .op_i     (aluOpE),
        .result_o (aluOutE)
    );

    assign hzd.rsE       = rsE;
    assign hzd.rtE       = rtE;
    assign hzd.writeRegE = writeRegE;

    // E/M register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            aluOutM    <= '0;
            writeDataM <= '0;
            writeRegM  <= '0;
        end else begin
            aluOutM    <= aluOutE;
            writeDataM <= writeDataE;
            writeRegM  <= writeRegE;
        end
    end

    // memory, word stores only
    assign dataAddrM_o   = aluOutM;
    assign dataWdataM_o  = writeDataM;
    assign dataWenM_o    = {4{memWriteM}};
    assign hzd.writeRegM = writeRegM;

    // M/W register, read data captured same cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            aluOutW   <= '0;
            readDataW <= '0;
            writeRegW <= '0;
        end else begin
            aluOutW   <= aluOutM;
            readDataW <= dataRdataM_i;
            writeRegW <= writeRegM;
        end
    end

    // writeback
    assign resultW       = memToRegW ? readDataW : aluOutW;
    assign hzd.writeRegW = writeRegW;

    hazardUnit uHazard (
        .hzd (hzd)
    );

endmodule

// ==== hdl/cpuCore.sv ====
`timescale 1ns/10ps

module cpuCore #(
    // boot vector, any word-aligned address
    parameter mipsPkg::word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic           clk,
    input  logic           reset_i,
    // instruction port, answered in the same cycle
    output mipsPkg::word_t pc_o,
    input  mipsPkg::word_t instr_i,
    // data port, memory stage
    output mipsPkg::word_t dataAddr_o,
    output logic [3:0]     dataWen_o,
    output mipsPkg::word_t dataWdata_o,
    input  mipsPkg::word_t dataRdata_i
);

    datapath #(
        .RESET_PC (RESET_PC)
    ) uDatapath (
        .clk          (clk),
        .reset_i      (reset_i),
        .instrF_i     (instr_i),
        .dataRdataM_i (dataRdata_i),
        .pcF_o        (pc_o),
        .dataAddrM_o  (dataAddr_o),
        .dataWenM_o   (dataWen_o),
        .dataWdataM_o (dataWdata_o)
    );

endmodule

// ==== tb/tbCpuCore.sv ====
`timescale 1ns/10ps

module tbCpuCore;

    localparam mipsPkg::word_t RESET_PC = 32'hBFC0_0000;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 256;
    localparam int MAX_STORES = 64;

    logic           clk;
    logic           reset_i;
    mipsPkg::word_t pc;
    mipsPkg::word_t instr;
    mipsPkg::word_t dataAddr;
    logic [3:0]     dataWen;
    mipsPkg::word_t dataWdata;
    mipsPkg::word_t dataRdata;
    mipsPkg::word_t imemOffset;

    // program and data images, empty words read as nop
    mipsPkg::word_t imem [IMEM_WORDS] = '{default: '0};
    mipsPkg::word_t dmem [DMEM_WORDS] = '{default: '0};

    // expected stores in program order
    mipsPkg::word_t expAddr [MAX_STORES];
    mipsPkg::word_t expData [MAX_STORES];
    int expCount   = 0;
    int progWords  = 0;
    int cycleLimit = 0;
    int storeIdx   = 0;
    int cycles     = 0;

    // one counter per checking process
    int resetErrors   = 0;
    int stimErrors    = 0;
    int storeErrors   = 0;
    int timeoutErrors = 0;

    cpuCore #(
        .RESET_PC (RESET_PC)
    ) DUT (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_o        (pc),
        .instr_i     (instr),
        .dataAddr_o  (dataAddr),
        .dataWen_o   (dataWen),
        .dataWdata_o (dataWdata),
        .dataRdata_i (dataRdata)
    );

    always #5 clk = ~clk;

    // word index counted from the boot vector
    assign imemOffset = (pc - RESET_PC) >> 2;
    assign instr      = (imemOffset < IMEM_WORDS) ? imem[imemOffset[5:0]] : '0;

    // data memory answers in the same cycle
    assign dataRdata = dmem[dataAddr[9:2]];

    task automatic loadStim();
        int             fd;
        int             n;
        string          line;
        byte            kind;
        mipsPkg::word_t addr;
        mipsPkg::word_t value;
        mipsPkg::word_t offset;
        fd = $fopen("tb/cpuStim.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/cpuStim.txt");
            stimErrors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // blank lines and comments carry nothing
                if (n > 1 && line.getc(0) != "#") begin
                    kind   = line.getc(0);
                    n      = $sscanf(line.substr(1, line.len() - 1), "%h %h", addr, value);
                    offset = (addr - RESET_PC) >> 2;
                    if (n != 2) begin
                        $display("malformed line in the stim file: %s", line);
                        stimErrors++;
                    end else if (kind == "P" && offset < IMEM_WORDS) begin
                        imem[offset[5:0]] = value;
                        progWords++;
                    end else if (kind == "S" && expCount < MAX_STORES) begin
                        expAddr[expCount[5:0]] = addr;
                        expData[expCount[5:0]] = value;
                        expCount++;
                    end else begin
                        $display("stim line out of range or of unknown kind: %s", line);
                        stimErrors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic checkResetState();
        assert (pc == RESET_PC) else begin
            $display("FAILED pc_o: got %h, expected %h", pc, RESET_PC);
            resetErrors++;
        end
        assert (dataWen == 4'h0) else begin
            $display("FAILED dataWen_o: got %h, expected %h", dataWen, 4'h0);
            resetErrors++;
        end
    endtask

    task automatic checkStore();
        // word stores only, so all four lanes or none
        assert (dataWen == 4'hF) else begin
            $display("FAILED dataWen_o: got %h, expected %h", dataWen, 4'hF);
            storeErrors++;
        end
        if (storeIdx >= expCount) begin
            $display("store to %h came after the last expected store", dataAddr);
            storeErrors++;
        end else begin
            assert (dataAddr == expAddr[storeIdx[5:0]]) else begin
                $display("FAILED dataAddr_o: got %h, expected %h",
                         dataAddr, expAddr[storeIdx[5:0]]);
                storeErrors++;
            end
            assert (dataWdata == expData[storeIdx[5:0]]) else begin
                $display("FAILED dataWdata_o: got %h, expected %h",
                         dataWdata, expData[storeIdx[5:0]]);
                storeErrors++;
            end
            storeIdx++;
        end
        // later loads read this back
        dmem[dataAddr[9:2]] = dataWdata;
    endtask

    task automatic finishRun();
        int total;
        total = resetErrors + stimErrors + storeErrors + timeoutErrors;
        $display("errors: %0d reset, %0d stim file, %0d store, %0d timeout",
                 resetErrors, stimErrors, storeErrors, timeoutErrors);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        clk     = 1'b0;
        reset_i = 1'b1;
        loadStim();
        // room for every stall the program can hit
        cycleLimit = 20 * progWords + 100;
        // reset over three rising edges
        repeat (3) begin
            @(negedge clk);
            checkResetState();
        end
        reset_i = 1'b0;
        // pc holds the boot vector until the next rising edge
        #1;
        checkResetState();
    end

    // outputs settle after the rising edge, sample them half a cycle later
    always @(negedge clk) begin
        if (dataWen != 4'h0) begin
            checkStore();
            if (expCount > 0 && storeIdx == expCount) begin
                finishRun();
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, stores missing: only %0d of %0d seen",
                     cycles, storeIdx, expCount);
            timeoutErrors++;
            finishRun();
        end
    end

endmodule

// ==== tb/cpuStim.txt ====
# P <fetch address> <instruction word>
# S <store address> <store data>, listed in the order the stores happen
# operands and alu results, sources at least three instructions back
P BFC00000 24011234
P BFC00004 3C02ABCD
P BFC00008 24038765
P BFC0000C 34048001
P BFC00010 00222821
P BFC00014 00233023
P BFC00018 00613824
P BFC0001C 00444025
P BFC00020 0061482A
P BFC00024 00015100
P BFC00028 AC040100
P BFC0002C AC050104
P BFC00030 AC060108
P BFC00034 AC07010C
P BFC00038 AC080110
P BFC0003C AC090114
P BFC00040 AC0A0118
# forwarding chain at distances 1, 2 and 3
P BFC00044 240B0005
P BFC00048 016B6021
P BFC0004C 016C6821
P BFC00050 01AB7023
P BFC00054 AC0E011C
P BFC00058 AC0D0120
# load-use, reads back the addu result stored at 0x104
P BFC0005C 8C0F0104
P BFC00060 01E18021
P BFC00064 AC100124
# branches and jumps, skipped stores write $1
P BFC00068 16000002
P BFC0006C AC0B0128
P BFC00070 AC01012C
P BFC00074 24110007
P BFC00078 122B0004
P BFC0007C AC11012C
P BFC00080 AC0C0130
P BFC00084 8C12011C
P BFC00088 124C0002
P BFC0008C AC120134
P BFC00090 AC010138
P BFC00094 15CC0002
P BFC00098 AC0D0138
P BFC0009C 0BF0002A
P BFC000A0 AC02013C
P BFC000A4 AC010140
P BFC000A8 AC030140
# self loop, delay slot reads as nop
P BFC000AC 0BF0002B
S 00000100 00008001
S 00000104 ABCD1234
S 00000108 00008ACF
S 0000010C 00000224
S 00000110 ABCD8001
S 00000114 00000001
S 00000118 00012340
S 0000011C 0000000A
S 00000120 0000000F
S 00000124 ABCD2468
S 00000128 00000005
S 0000012C 00000007
S 00000130 0000000A
S 00000134 0000000A
S 00000138 0000000F
S 0000013C ABCD0000
S 00000140 FFFF8765

// ==== tb.f ====
common/mipsPkg.sv
common/hazardIf.sv
datapath/regFile.sv
datapath/alu.sv
hdl/hazardUnit.sv
hdl/controlDecoder.sv
datapath/datapath.sv
hdl/cpuCore.sv
tb/tbCpuCore.sv

// ==== run.sh ====
#!/bin/sh
# build from the file list, run, then look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f tb.f --top-module tbCpuCore -o tbCpuCore || exit 1
simOut=$(./obj_dir/tbCpuCore)
echo "$simOut"
echo "$simOut" | grep -qx "Finished with no errors" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
